//--- Bender.yml
package:
  name: ppu

export_include_dirs:
  - .

sources:
  - ppu_pkg.sv
  - posit_decode.sv
  - posit_encode.sv
  - posit_core.sv
  - handle_special_or_trivial.sv
  - ppu_top.sv
  - target: test
    files:
      - ppu_checker.sv
      - tb_ppu.sv

//--- files.f
+incdir+.
ppu_pkg.sv
posit_decode.sv
posit_encode.sv
posit_core.sv
handle_special_or_trivial.sv
ppu_top.sv
ppu_checker.sv
tb_ppu.sv

//--- handle_special_or_trivial.sv
`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

module handle_special_or_trivial (
  input  wire ppu_pkg::ppu_op_t op,
  input  wire [`PPU_N-1:0]      p1_in,
  input  wire [`PPU_N-1:0]      p2_in,
  output logic [`PPU_N-1:0]     pout
);

  import ppu_pkg::*;

  logic [`PPU_N-1:0] p_mul;
  logic [`PPU_N-1:0] p_add;
  logic [`PPU_N-1:0] p_sub;
  logic [`PPU_N-1:0] p_div;

  lut_mul lut_mul_inst (
    .p1    (p1_in),
    .p2    (p2_in),
    .p_out (p_mul)
  );

  lut_add lut_add_inst (
    .p1    (p1_in),
    .p2    (p2_in),
    .p_out (p_add)
  );

  lut_sub lut_sub_inst (
    .p1    (p1_in),
    .p2    (p2_in),
    .p_out (p_sub)
  );

  lut_div lut_div_inst (
    .p1    (p1_in),
    .p2    (p2_in),
    .p_out (p_div)
  );

  always_comb begin
    case (op)
      ADD:     pout = p_add;
      SUB:     pout = p_sub;
      MUL:     pout = p_mul;
      default: pout = p_div;
    endcase
  end

endmodule

module lut_mul (
  input  wire [`PPU_N-1:0]  p1,
  input  wire [`PPU_N-1:0]  p2,
  output logic [`PPU_N-1:0] p_out
);

  import ppu_pkg::*;

  always_comb begin
    case (p1)
      ZERO:    p_out = (p2 == NAR) ? NAR : ZERO;
      NAR:     p_out = NAR;
      default: p_out = p2;
    endcase
  end

endmodule

module lut_add (
  input  wire [`PPU_N-1:0]  p1,
  input  wire [`PPU_N-1:0]  p2,
  output logic [`PPU_N-1:0] p_out
);

  import ppu_pkg::*;

  always_comb begin
    case (p1)
      ZERO:    p_out = p2;
      NAR:     p_out = NAR;
      default: p_out = (p2 == c2(p1)) ? ZERO : (p2 == ZERO) ? p1 : NAR;
    endcase
  end

endmodule

module lut_sub (
  input  wire [`PPU_N-1:0]  p1,
  input  wire [`PPU_N-1:0]  p2,
  output logic [`PPU_N-1:0] p_out
);

  import ppu_pkg::*;

  // Negation leaves ZERO and NAR unchanged.
  always_comb begin
    case (p1)
      ZERO:    p_out = c2(p2);
      NAR:     p_out = NAR;
      default: p_out = (p2 == p1) ? ZERO : (p2 == ZERO) ? p1 : NAR;
    endcase
  end

endmodule

module lut_div (
  input  wire [`PPU_N-1:0]  p1,
  input  wire [`PPU_N-1:0]  p2,
  output logic [`PPU_N-1:0] p_out
);

  import ppu_pkg::*;

  // Regular by regular also ends up as NaR.
  always_comb begin
    case (p1)
      ZERO:    p_out = (p2 == NAR || p2 == ZERO) ? NAR : ZERO;
      default: p_out = NAR;
    endcase
  end

endmodule

`default_nettype wire

//--- posit_core.sv
`timescale 1ns/1ps
`default_nettype none

module posit_core (
  input  wire ppu_pkg::ppu_op_t             op,
  input  wire                               sign1,
  input  wire signed [ppu_pkg::SCALE_W-1:0] scale1,
  input  wire [ppu_pkg::FRAC_W-1:0]         frac1,
  input  wire                               sign2,
  input  wire signed [ppu_pkg::SCALE_W-1:0] scale2,
  input  wire [ppu_pkg::FRAC_W-1:0]         frac2,
  output logic                              sign,
  output logic signed [ppu_pkg::SCALE_W-1:0] scale,
  output logic [ppu_pkg::FRAC_W+1:0]        frac_out
);

  import ppu_pkg::*;

  // Carry, hidden bit, fraction, then guard, round and sticky.
  localparam int AW = FRAC_W + 4;
  localparam int LZ_W = $clog2(AW) + 1;
  localparam int MAX_SH = FRAC_W + 3;

  logic [2*FRAC_W-1:0]       prod;
  logic [2*FRAC_W-1:0]       prod_n;
  logic signed [SCALE_W-1:0] mul_scale;
  logic [FRAC_W+1:0]         mul_frac;

  logic                      sign2_eff;
  logic                      swap;
  logic                      sign_big;
  logic signed [SCALE_W-1:0] scale_big;
  logic signed [SCALE_W-1:0] diff;
  logic [SCALE_W-1:0]        shamt;
  logic [FRAC_W-1:0]         frac_big;
  logic [FRAC_W-1:0]         frac_small;
  logic [2*FRAC_W+2:0]       wide;
  logic [AW-1:0]             big_ext;
  logic [AW-1:0]             small_ext;
  logic [AW-1:0]             sum;
  logic [AW-1:0]             norm;
  logic [LZ_W-1:0]           lz;
  logic signed [SCALE_W-1:0] add_scale;
  logic [FRAC_W+1:0]         add_frac;

  // Product of two fractions in [1,2) lies in [1,4).
  assign prod      = frac1 * frac2;
  assign prod_n    = prod[2*FRAC_W-1] ? prod : prod << 1;
  assign mul_scale = scale1 + scale2 + SCALE_W'(prod[2*FRAC_W-1]);
  assign mul_frac  = {prod_n[2*FRAC_W-1 -: FRAC_W+1], |prod_n[FRAC_W-2:0]};

  // SUB flips the sign of the second operand.
  assign sign2_eff = sign2 ^ (op == SUB);

  // Operand 2 has the larger magnitude.
  assign swap = (scale2 > scale1) || (scale2 == scale1 && frac2 > frac1);

  assign sign_big   = swap ? sign2_eff : sign1;
  assign scale_big  = swap ? scale2 : scale1;
  assign frac_big   = swap ? frac2 : frac1;
  assign frac_small = swap ? frac1 : frac2;
  assign diff       = swap ? scale2 - scale1 : scale1 - scale2;

  // Past MAX_SH the smaller operand only feeds the sticky bit.
  assign shamt = (diff > MAX_SH) ? SCALE_W'(MAX_SH) : diff;

  assign wide      = {frac_small, {(FRAC_W+3){1'b0}}} >> shamt;
  assign big_ext   = {1'b0, frac_big, 3'b000};
  assign small_ext = {1'b0, wide[2*FRAC_W+2 -: FRAC_W+2], |wide[FRAC_W:0]};

  assign sum = (sign1 ^ sign2_eff) ? big_ext - small_ext : big_ext + small_ext;

  // Leading zero count of the sum.
  always_comb begin
    lz = LZ_W'(AW);
    for (int i = 0; i < AW; i++) begin
      if (sum[i]) begin
        lz = LZ_W'(AW - 1 - i);
      end
    end
  end

  assign norm = sum << lz;

  // The hidden bit of big_ext sits one place below the carry.
  assign add_scale = scale_big + 1 - lz;
  assign add_frac  = {norm[AW-1 -: FRAC_W+1], |norm[2:0]};

  // DIV results always come from the special tables.
  assign sign     = (op == MUL) ? sign1 ^ sign2 : sign_big;
  assign scale    = (op == MUL) ? mul_scale : add_scale;
  assign frac_out = (op == MUL) ? mul_frac : add_frac;

endmodule

`default_nettype wire

//--- posit_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

module posit_decode (
  input  wire [`PPU_N-1:0]                   p,
  output logic                               sign,
  output logic signed [ppu_pkg::SCALE_W-1:0] scale,
  output logic [ppu_pkg::FRAC_W-1:0]         frac
);

  import ppu_pkg::*;

  localparam int RUN_W = $clog2(`PPU_N) + 1;

  logic [`PPU_N-1:0]         mag;
  logic [`PPU_N-2:0]         body;
  logic [`PPU_N-2:0]         rem;
  logic [`PPU_N-2:0]         rem_f;
  logic [RUN_W-1:0]          run;
  logic                      done;
  logic signed [SCALE_W-1:0] run_s;
  logic signed [SCALE_W-1:0] k;
  logic signed [SCALE_W-1:0] e;

  assign sign = p[`PPU_N-1];

  // Negative posits are decoded from their magnitude.
  assign mag  = sign ? c2(p) : p;
  assign body = mag[`PPU_N-2:0];

  // Length of the regime run.
  always_comb begin
    run  = '0;
    done = 1'b0;
    for (int i = `PPU_N - 2; i >= 0; i--) begin
      if (!done && body[i] == body[`PPU_N-2]) begin
        run = run + 1'b1;
      end else begin
        done = 1'b1;
      end
    end
  end

  assign run_s = SCALE_W'(run);

  // A run of ones gives k = run - 1, a run of zeros gives k = -run.
  assign k = body[`PPU_N-2] ? run_s - 1 : -run_s;

  // Drop the regime and its terminating bit.
  assign rem = body << (run + 1'b1);

  assign e     = SCALE_W'(rem >> (`PPU_N - 1 - `PPU_ES));
  assign rem_f = rem << `PPU_ES;

  assign scale = (k <<< `PPU_ES) + e;
  assign frac  = {1'b1, rem_f[`PPU_N-2 -: FRAC_W-1]};

endmodule

`default_nettype wire

//--- posit_encode.sv
`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

module posit_encode (
  input  wire                               sign,
  input  wire signed [ppu_pkg::SCALE_W-1:0] scale,
  input  wire [ppu_pkg::FRAC_W+1:0]         frac_out,
  output logic [`PPU_N-1:0]                 p
);

  import ppu_pkg::*;

  // Exponent, fraction, guard and sticky behind the regime.
  localparam int TW = `PPU_ES + FRAC_W + 1;
  // Zeros below the tail keep the bits that the regime pushes out.
  localparam int VW = TW + 2 + `PPU_N;
  localparam int MAX_SCALE = (`PPU_N - 2) << `PPU_ES;
  localparam int MIN_SCALE = -((`PPU_N - 1) << `PPU_ES);

  logic signed [SCALE_W-1:0] k;
  logic [SCALE_W-1:0]        e;
  logic [SCALE_W-1:0]        shamt;
  logic [TW-1:0]             tail;
  logic signed [VW-1:0]      v;
  logic [`PPU_N-2:0]         body;
  logic                      round_bit;
  logic                      sticky;
  logic                      round_up;
  logic [`PPU_N-1:0]         body_r;
  logic [`PPU_N-2:0]         mag;

  assign k = scale >>> `PPU_ES;
  assign e = scale & SCALE_W'((1 << `PPU_ES) - 1);

  assign tail = (TW'(e) << (FRAC_W + 1)) | TW'(frac_out[FRAC_W:0]);

  // For k < 0 the shift is -k-1, which is ~k.
  assign shamt = k[SCALE_W-1] ? ~k : k;

  // Seed "10" or "01" and let the arithmetic shift grow the regime run.
  assign v = $signed({~k[SCALE_W-1], k[SCALE_W-1], tail, {`PPU_N{1'b0}}}) >>> shamt;

  assign body      = v[VW-1 -: `PPU_N-1];
  assign round_bit = v[VW-`PPU_N];
  assign sticky    = |v[VW-`PPU_N-1:0];

  // Round to nearest, ties to even.
  assign round_up = round_bit && (sticky || body[0]);
  assign body_r   = {1'b0, body} + round_up;

  always_comb begin
    if (scale > MAX_SCALE || body_r[`PPU_N-1]) begin
      mag = '1;
    end else if (scale < MIN_SCALE || body_r == '0) begin
      mag = {{(`PPU_N-2){1'b0}}, 1'b1};
    end else begin
      mag = body_r[`PPU_N-2:0];
    end
  end

  assign p = sign ? c2({1'b0, mag}) : {1'b0, mag};

endmodule

`default_nettype wire

//--- ppu_cfg.svh
`ifndef PPU_CFG_SVH
`define PPU_CFG_SVH

// Posit width in bits.
`define PPU_N 8

// Size of the exponent field.
`define PPU_ES 0

`endif

//--- ppu_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

module ppu_checker (
  input wire              clk,
  input wire              rst_n,
  input wire              out_valid,
  input wire [`PPU_N-1:0] pout
);

  localparam int LATENCY = 3;

  string             name_q[$];
  logic [`PPU_N-1:0] exp_q[$];
  int                due_q[$];
  int                cycle = 0;
  int                done_count = 0;
  int                pass_count = 0;
  int                fail_count = 0;
  int                other_count = 0;
  int                error_count = 0;

  // Rising edges seen so far.
  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // Called on the falling edge where a pair is driven into the DUT.
  task automatic expect_result(input string name, input logic [`PPU_N-1:0] exp);
    name_q.push_back(name);
    exp_q.push_back(exp);
    due_q.push_back(cycle + LATENCY);
  endtask

  always @(negedge clk) begin : sample
    string             name;
    logic [`PPU_N-1:0] exp;
    int                due;
    if (!rst_n) begin
      if (cycle >= 1 && out_valid !== 1'b0) begin
        $display("out_valid is not low while reset is held (cycle %0d)", cycle);
        other_count++;
        error_count++;
      end
    end else if (out_valid === 1'b1) begin
      if (name_q.size() == 0) begin
        $display("out_valid went high at cycle %0d with no result outstanding", cycle);
        other_count++;
        error_count++;
      end else begin
        name = name_q.pop_front();
        exp  = exp_q.pop_front();
        due  = due_q.pop_front();
        if (pout !== exp) begin
          $display("Error %s: expected %h, actual %h", name, exp, pout);
          fail_count++;
          error_count++;
        end else if (cycle != due) begin
          $display("Test %s came back at cycle %0d but was due at cycle %0d",
                   name, cycle, due);
          fail_count++;
          error_count++;
        end else begin
          $display("ok     %s: %h", name, pout);
          pass_count++;
        end
        done_count++;
      end
    end else if (out_valid !== 1'b0) begin
      $display("out_valid is unknown at cycle %0d", cycle);
      other_count++;
      error_count++;
    end
  end

  task automatic print_summary();
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d other errors, %0d outstanding",
             done_count, pass_count, fail_count, other_count, name_q.size());
  endtask

endmodule

`default_nettype wire

//--- ppu_pkg.sv
`default_nettype none

`include "ppu_cfg.svh"

package ppu_pkg;

  localparam int OP_SIZE = 2;

  typedef enum logic [OP_SIZE-1:0] {
    ADD = 2'd0,
    SUB = 2'd1,
    MUL = 2'd2,
    DIV = 2'd3
  } ppu_op_t;

  // Signed scale, with room for the sum of two extreme scales.
  localparam int SCALE_W = $clog2((`PPU_N - 1) << `PPU_ES) + 3;

  // Fraction including the hidden bit.
  localparam int FRAC_W = `PPU_N - 2;

  localparam logic [`PPU_N-1:0] ZERO = '0;
  localparam logic [`PPU_N-1:0] NAR = {1'b1, {(`PPU_N-1){1'b0}}};

  function automatic logic [`PPU_N-1:0] c2(input logic [`PPU_N-1:0] a);
    return ~a + 1'b1;
  endfunction

endpackage

`default_nettype wire

//--- ppu_stim.txt
# name op p1 p2 expected
# Operands and results are 8-bit posits with es 0, in hex.
mul_zero_x      MUL 00 48 00
mul_x_zero      MUL 48 00 00
mul_nar_x       MUL 80 40 80
mul_x_nar       MUL 40 80 80
mul_zero_nar    MUL 00 80 80
add_zero_x      ADD 00 B0 B0
add_x_zero      ADD 5C 00 5C
add_nar_zero    ADD 80 00 80
add_x_nar       ADD 30 80 80
sub_zero_x      SUB 00 50 B0
sub_zero_neg    SUB 00 C8 38
sub_x_zero      SUB 64 00 64
sub_x_nar       SUB 20 80 80
div_by_zero     DIV 40 00 80
div_zero_x      DIV 00 58 00
div_zero_zero   DIV 00 00 80
div_nar_x       DIV 80 40 80
add_cancel      ADD 50 B0 00
add_cancel_neg  ADD E4 1C 00
sub_self        SUB 6A 6A 00
sub_self_neg    SUB 9F 9F 00
div_regular     DIV 60 40 80
div_regular_neg DIV C0 50 80
mul_exact       MUL 50 50 62
mul_neg         MUL B0 60 98
mul_both_neg    MUL C0 A0 60
mul_tie_up      MUL 48 58 62
mul_tie_down    MUL 50 5C 66
mul_round       MUL 42 5A 5E
mul_small       MUL 14 14 06
mul_scales      MUL 10 7D 74
mul_sat_max     MUL 7E 78 7F
mul_sat_min     MUL 01 01 01
mul_sat_min_neg MUL 01 FE FF
add_simple      ADD 40 40 60
add_scales      ADD 50 10 58
add_mixed_sign  ADD B0 60 20
add_both_neg    ADD C0 E0 B0
add_tie_down    ADD 40 01 40
add_tie_up      ADD 41 01 42
add_round       ADD 7D 68 7D
add_sat_max     ADD 7F 7F 7F
add_sticky      ADD 7C 01 7C
sub_simple      SUB 68 48 58
sub_neg_result  SUB 40 64 B0
sub_neg_ops     SUB E0 A0 50
sub_near_cancel SUB 41 40 02

//--- ppu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

module ppu_top (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   in_valid,
  input  wire ppu_pkg::ppu_op_t op,
  input  wire [`PPU_N-1:0]      p1,
  input  wire [`PPU_N-1:0]      p2,
  output logic                  out_valid,
  output logic [`PPU_N-1:0]     pout
);

  import ppu_pkg::*;

  logic                      s1_valid;
  ppu_op_t                   s1_op;
  logic [`PPU_N-1:0]         s1_p1;
  logic [`PPU_N-1:0]         s1_p2;

  logic                      d1_sign;
  logic signed [SCALE_W-1:0] d1_scale;
  logic [FRAC_W-1:0]         d1_frac;
  logic                      d2_sign;
  logic signed [SCALE_W-1:0] d2_scale;
  logic [FRAC_W-1:0]         d2_frac;
  logic [`PPU_N-1:0]         special_p;
  logic                      special;

  logic                      s2_valid;
  ppu_op_t                   s2_op;
  logic                      s2_sign1;
  logic signed [SCALE_W-1:0] s2_scale1;
  logic [FRAC_W-1:0]         s2_frac1;
  logic                      s2_sign2;
  logic signed [SCALE_W-1:0] s2_scale2;
  logic [FRAC_W-1:0]         s2_frac2;
  logic [`PPU_N-1:0]         s2_special_p;
  logic                      s2_special;

  logic                      c_sign;
  logic signed [SCALE_W-1:0] c_scale;
  logic [FRAC_W+1:0]         c_frac;
  logic [`PPU_N-1:0]         enc_p;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= in_valid;
      s2_valid  <= s1_valid;
      out_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      s1_op <= op;
      s1_p1 <= p1;
      s1_p2 <= p2;
    end
  end

  posit_decode u_dec1 (
    .p     (s1_p1),
    .sign  (d1_sign),
    .scale (d1_scale),
    .frac  (d1_frac)
  );

  posit_decode u_dec2 (
    .p     (s1_p2),
    .sign  (d2_sign),
    .scale (d2_scale),
    .frac  (d2_frac)
  );

  handle_special_or_trivial u_special (
    .op    (s1_op),
    .p1_in (s1_p1),
    .p2_in (s1_p2),
    .pout  (special_p)
  );

  // Pairs that the tables resolve, including every division.
  assign special = s1_p1 == ZERO || s1_p1 == NAR || s1_p2 == ZERO || s1_p2 == NAR
                || s1_op == DIV
                || (s1_op == ADD && s1_p2 == c2(s1_p1))
                || (s1_op == SUB && s1_p2 == s1_p1);

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      s2_op        <= s1_op;
      s2_sign1     <= d1_sign;
      s2_scale1    <= d1_scale;
      s2_frac1     <= d1_frac;
      s2_sign2     <= d2_sign;
      s2_scale2    <= d2_scale;
      s2_frac2     <= d2_frac;
      s2_special_p <= special_p;
      s2_special   <= special;
    end
  end

  posit_core u_core (
    .op       (s2_op),
    .sign1    (s2_sign1),
    .scale1   (s2_scale1),
    .frac1    (s2_frac1),
    .sign2    (s2_sign2),
    .scale2   (s2_scale2),
    .frac2    (s2_frac2),
    .sign     (c_sign),
    .scale    (c_scale),
    .frac_out (c_frac)
  );

  posit_encode u_enc (
    .sign     (c_sign),
    .scale    (c_scale),
    .frac_out (c_frac),
    .p        (enc_p)
  );

  always_ff @(posedge clk) begin
    if (s2_valid) begin
      pout <= s2_special ? s2_special_p : enc_p;
    end
  end

endmodule

`default_nettype wire

//--- tb_ppu.sv
`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

module tb_ppu;

  import ppu_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 10;

  logic              clk;
  logic              rst_n;
  logic              in_valid;
  ppu_op_t           op;
  logic [`PPU_N-1:0] p1;
  logic [`PPU_N-1:0] p2;
  wire               out_valid;
  wire [`PPU_N-1:0]  pout;

  string             name_q[$];
  ppu_op_t           op_q[$];
  logic [`PPU_N-1:0] p1_q[$];
  logic [`PPU_N-1:0] p2_q[$];
  logic [`PPU_N-1:0] exp_q[$];
  int                gap_q[$];
  int                total_idle;
  integer            seed;
  bit                loaded;
  bit                stim_error;

  ppu_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .op        (op),
    .p1        (p1),
    .p2        (p2),
    .out_valid (out_valid),
    .pout      (pout)
  );

  ppu_checker chk_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .pout      (pout)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic bit op_known(input string s);
    return s == "ADD" || s == "SUB" || s == "MUL" || s == "DIV";
  endfunction

  function automatic ppu_op_t op_from_name(input string s);
    if (s == "SUB") begin
      return SUB;
    end else if (s == "MUL") begin
      return MUL;
    end else if (s == "DIV") begin
      return DIV;
    end
    return ADD;
  endfunction

  task automatic load_stimulus();
    int                fd;
    int                cnt;
    int                line_no;
    string             line;
    string             tname;
    string             top;
    logic [`PPU_N-1:0] a;
    logic [`PPU_N-1:0] b;
    logic [`PPU_N-1:0] e;
    line_no = 0;
    fd = $fopen("ppu_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open ppu_stim.txt");
      stim_error = 1'b1;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      cnt = $fgets(line, fd);
      line_no++;
      // Blank lines and lines starting with # carry no test.
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      cnt = $sscanf(line, "%s %s %h %h %h", tname, top, a, b, e);
      if (cnt != 5 || !op_known(top)) begin
        $display("Stimulus line %0d could not be read as a test", line_no);
        stim_error = 1'b1;
        continue;
      end
      name_q.push_back(tname);
      op_q.push_back(op_from_name(top));
      p1_q.push_back(a);
      p2_q.push_back(b);
      exp_q.push_back(e);
    end
    $fclose(fd);
    if (name_q.size() == 0) begin
      $display("The stimulus file holds no tests");
      stim_error = 1'b1;
    end
  endtask

  // Roughly one test in four is followed by one to four idle cycles.
  task automatic plan_gaps();
    logic [31:0] r;
    int          g;
    total_idle = 0;
    for (int i = 0; i < name_q.size(); i++) begin
      r = $random(seed);
      g = (r[1:0] == 2'b00) ? r[3:2] + 1 : 0;
      gap_q.push_back(g);
      total_idle += g;
    end
  endtask

  initial begin : watchdog
    wait (loaded);
    @(posedge rst_n);
    #((name_q.size() + total_idle + 3 + 20) * CLK_PERIOD);
    $display("Timeout: the DUT did not return every result in time");
    $display("sim failed");
    $finish;
  end

  initial begin
    seed       = 32'hb979e231;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    op         = ADD;
    p1         = '0;
    p2         = '0;
    loaded     = 1'b0;
    stim_error = 1'b0;
    load_stimulus();
    plan_gaps();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    for (int i = 0; i < name_q.size(); i++) begin
      in_valid = 1'b1;
      op       = op_q[i];
      p1       = p1_q[i];
      p2       = p2_q[i];
      chk_i.expect_result(name_q[i], exp_q[i]);
      @(negedge clk);
      if (gap_q[i] > 0) begin
        in_valid = 1'b0;
        repeat (gap_q[i]) @(negedge clk);
      end
    end
    in_valid = 1'b0;
    wait (chk_i.done_count == name_q.size());
    // A few more cycles to catch any stray out_valid.
    repeat (4) @(negedge clk);
    chk_i.print_summary();
    if (chk_i.error_count == 0 && !stim_error) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
